// File: i3c_target.f
+incdir+verilog
+incdir+test
verilog/i3c_target_pkg.sv
verilog/i3c_bus_if.sv
verilog/i3c_bus_sampler.sv
verilog/i3c_hold_timer.sv
verilog/i3c_target_fsm.sv
verilog/i3c_target_top.sv
test/tb_i3c_target.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
  --top-module tb_i3c_target -f i3c_target.f

sim_out=$(./obj_dir/Vtb_i3c_target)
echo "$sim_out"

if echo "$sim_out" | grep -qx "Test OK"; then
  exit 0
fi
exit 1

// File: test/tb_i3c_host_tasks.svh
`ifndef TB_I3C_HOST_TASKS_SVH
`define TB_I3C_HOST_TASKS_SVH

// Host bus model, every change lands 1 ns after a rising clock edge
task automatic wait_clks(input int n);
  repeat (n) @(posedge clk);
  #1;
endtask

// SDA falls while SCL is high, monitor pulse follows
task automatic send_start();
  sda_host = 1'b0;
  wait_clks(QUARTER);
  start_det = 1'b1;
  wait_clks(1);
  start_det = 1'b0;
  wait_clks(HALF);
  scl = 1'b0;
endtask

// Entered with SCL low, leaves the bus idle
task automatic send_stop();
  wait_clks(QUARTER);
  sda_host = 1'b0;
  wait_clks(QUARTER);
  scl = 1'b1;
  wait_clks(QUARTER);
  sda_host = 1'b1;
  stop_det = 1'b1;
  wait_clks(1);
  stop_det = 1'b0;
  wait_clks(HALF);
endtask

// Data changes in the middle of the low phase
task automatic write_bit(input logic b);
  wait_clks(QUARTER);
  sda_host = b;
  wait_clks(QUARTER);
  scl = 1'b1;
  wait_clks(HALF);
  scl = 1'b0;
endtask

// Host releases SDA and samples the wired bus while SCL is high
task automatic read_bit(output logic b);
  wait_clks(QUARTER);
  sda_host = 1'b1;
  wait_clks(QUARTER);
  scl = 1'b1;
  wait_clks(QUARTER);
  b = sda_bus;
  wait_clks(QUARTER);
  scl = 1'b0;
endtask

// Eight bits MSB first, no ACK bit
task automatic shift_out_byte(input logic [7:0] b);
  logic [7:0] sr;
  sr = b;
  repeat (8) begin
    write_bit(sr[7]);
    sr = sr << 1;
  end
endtask

// Byte plus ninth bit, ack_sda low means the target acknowledged
task automatic write_byte(input logic [7:0] b, output logic ack_sda);
  shift_out_byte(b);
  read_bit(ack_sda);
endtask

// Read eight bits, then ACK or NACK them
task automatic read_byte(input logic ack, output logic [7:0] b);
  logic v;
  b = '0;
  repeat (8) begin
    read_bit(v);
    b = {b[6:0], v};
  end
  write_bit(!ack);
endtask

`endif

// File: test/tb_i3c_target.sv
`timescale 1ns/1ns
`include "i3c_target_params.svh"

module tb_i3c_target;

  // SCL half period in clocks
  localparam int HALF    = 40;
  localparam int QUARTER = HALF / 2;
  // Bits clocked over all tests, 100 clocks allowed for each
  localparam int TEST_BITS      = 150;
  localparam int TIMEOUT_CYCLES = TEST_BITS * 100 + 2000;

  localparam logic [`I3C_ADDR_W-1:0] OWN_ADDR   = 7'h2a;
  localparam logic [`I3C_ADDR_W-1:0] OTHER_ADDR = 7'h35;

  logic                      clk;
  logic                      rst_n;
  logic                      enable;
  logic                      scl;
  logic                      sda_host;
  logic                      sda_bus;
  logic                      start_det;
  logic                      stop_det;
  logic                      sda_out;
  logic                      transmitting;
  logic                      tx_rvalid;
  logic [7:0]                tx_rdata;
  logic                      tx_rready;
  logic                      rx_wvalid;
  i3c_target_pkg::rx_entry_t rx_wdata;
  logic                      rx_wready;
  logic [`I3C_TIMING_W-1:0]  t_r;
  logic [`I3C_TIMING_W-1:0]  tsu_dat;
  logic [`I3C_TIMING_W-1:0]  thd_dat;
  logic [`I3C_ADDR_W-1:0]    target_addr;
  logic                      idle;
  logic                      evt_nack;
  logic                      evt_done;
  logic                      evt_unexp_stop;
  logic                      evt_read_cmd;

  // Recorded FIFO traffic and event counts
  i3c_target_pkg::rx_entry_t rx_q[$];
  logic [7:0]                tx_q[$];
  logic [7:0]                nack_cnt;
  logic [7:0]                done_cnt;
  logic [7:0]                unexp_cnt;
  logic [7:0]                read_cmd_cnt;
  logic [7:0]                pop_cnt;
  logic [31:0]               lcg_state;
  int                        errors;
  int                        checks;
  int                        cycle_count;

  // Open-drain bus, host and target both pull low
  assign sda_bus = sda_host & sda_out;

  initial clk = 1'b0;
  always #4 clk = ~clk;

  i3c_target_top UUT (
    .clk_i                     (clk),
    .rst_ni                    (rst_n),
    .target_enable_i           (enable),
    .scl_i                     (scl),
    .sda_i                     (sda_bus),
    .start_det_i               (start_det),
    .stop_det_i                (stop_det),
    .sda_o                     (sda_out),
    .target_transmitting_o     (transmitting),
    .tx_fifo_rvalid_i          (tx_rvalid),
    .tx_fifo_rdata_i           (tx_rdata),
    .tx_fifo_rready_o          (tx_rready),
    .rx_fifo_wvalid_o          (rx_wvalid),
    .rx_fifo_wdata_o           (rx_wdata),
    .rx_fifo_wready_i          (rx_wready),
    .t_r_i                     (t_r),
    .tsu_dat_i                 (tsu_dat),
    .thd_dat_i                 (thd_dat),
    .target_addr_i             (target_addr),
    .target_idle_o             (idle),
    .event_target_nack_o       (evt_nack),
    .event_cmd_complete_o      (evt_done),
    .event_unexp_stop_o        (evt_unexp_stop),
    .event_read_cmd_received_o (evt_read_cmd)
  );

  `include "tb_i3c_host_tasks.svh"

  // Strobes are sampled mid-cycle, away from both edges
  always @(negedge clk) begin
    if (rx_wvalid) rx_q.push_back(rx_wdata);
    if (evt_nack) nack_cnt = nack_cnt + 8'd1;
    if (evt_done) done_cnt = done_cnt + 8'd1;
    if (evt_unexp_stop) unexp_cnt = unexp_cnt + 8'd1;
    if (evt_read_cmd) read_cmd_cnt = read_cmd_cnt + 8'd1;
    if (tx_rready) begin
      pop_cnt = pop_cnt + 8'd1;
      if (tx_q.size() == 0) begin
        errors++;
        $display("ERROR: the TX FIFO was popped while it held no data");
      end else begin
        void'(tx_q.pop_front());
      end
    end
  end

  // TX FIFO read side follows the queue
  always @(posedge clk) begin
    #1;
    tx_rvalid = (tx_q.size() != 0);
    tx_rdata  = (tx_q.size() != 0) ? tx_q[0] : 8'h00;
  end

  function automatic logic [7:0] next_rand_byte();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic clear_counts();
    rx_q.delete();
    nack_cnt     = '0;
    done_cnt     = '0;
    unexp_cnt    = '0;
    read_cmd_cnt = '0;
    pop_cnt      = '0;
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_entry(input string name, input i3c_target_pkg::rx_entry_t got,
                             input i3c_target_pkg::rx_entry_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  // Oldest recorded RX write against the expected tag and byte
  task automatic expect_entry(input i3c_target_pkg::acq_tag_e tag, input logic [7:0] data);
    i3c_target_pkg::rx_entry_t exp;
    exp.tag  = tag;
    exp.data = data;
    if (rx_q.size() == 0) begin
      errors++;
      $display("ERROR: no RX FIFO write seen where tag %0d with data 0x%h was due", tag, data);
    end else begin
      check_entry("rx_fifo_wdata_o", rx_q.pop_front(), exp);
    end
  endtask

  task automatic idle_after_reset();
    check_bit("target_idle_o", idle, 1'b1);
    check_bit("sda_o", sda_out, 1'b1);
    check_bit("target_transmitting_o", transmitting, 1'b0);
    check_bit("rx_fifo_wvalid_o", rx_wvalid, 1'b0);
    check_bit("tx_fifo_rready_o", tx_rready, 1'b0);
    check_byte("event outputs", {4'h0, evt_nack, evt_done, evt_unexp_stop, evt_read_cmd}, 8'h00);
  endtask

  task automatic private_write();
    logic [7:0] data[$];
    logic [7:0] addr_byte;
    logic       ack_sda;
    addr_byte = {OWN_ADDR, 1'b0};
    clear_counts();
    send_start();
    write_byte(addr_byte, ack_sda);
    check_bit("SDA on address ACK bit", ack_sda, 1'b0);
    repeat (4) begin
      data.push_back(next_rand_byte());
      write_byte(data[data.size()-1], ack_sda);
      check_bit("SDA on data ACK bit", ack_sda, 1'b0);
    end
    send_stop();
    expect_entry(i3c_target_pkg::AcqStart, addr_byte);
    foreach (data[i]) expect_entry(i3c_target_pkg::AcqData, data[i]);
    // Rising SCL of the stop shifts a zero in behind the last byte
    expect_entry(i3c_target_pkg::AcqStop, {data[3][6:0], 1'b0});
    check_byte("RX FIFO extra writes", 8'(rx_q.size()), 8'd0);
    check_byte("event_cmd_complete_o pulses", done_cnt, 8'd1);
  endtask

  task automatic addr_mismatch();
    logic ack_sda;
    clear_counts();
    send_start();
    write_byte({OTHER_ADDR, 1'b0}, ack_sda);
    check_bit("SDA on address ACK bit", ack_sda, 1'b1);
    write_byte(next_rand_byte(), ack_sda);
    check_bit("SDA on data ACK bit", ack_sda, 1'b1);
    send_stop();
    check_byte("RX FIFO writes", 8'(rx_q.size()), 8'd0);
    check_byte("event_cmd_complete_o pulses", done_cnt, 8'd0);
  endtask

  task automatic private_read();
    logic [7:0] exp[$];
    logic [7:0] got;
    logic [7:0] addr_byte;
    logic       ack_sda;
    addr_byte = {OWN_ADDR, 1'b1};
    clear_counts();
    repeat (3) begin
      exp.push_back(next_rand_byte());
      tx_q.push_back(exp[exp.size()-1]);
    end
    send_start();
    write_byte(addr_byte, ack_sda);
    check_bit("SDA on address ACK bit", ack_sda, 1'b0);
    // Host ACKs all but the last byte
    foreach (exp[i]) begin
      read_byte(i != 2, got);
      check_byte("byte read from sda_o", got, exp[i]);
    end
    wait_clks(QUARTER);
    check_bit("sda_o after host NACK", sda_out, 1'b1);
    check_bit("target_transmitting_o after host NACK", transmitting, 1'b0);
    send_stop();
    check_byte("event_read_cmd_received_o pulses", read_cmd_cnt, 8'd1);
    check_byte("TX FIFO pops", pop_cnt, 8'd2);
    check_byte("event_unexp_stop_o pulses", unexp_cnt, 8'd0);
    check_byte("event_cmd_complete_o pulses", done_cnt, 8'd1);
    expect_entry(i3c_target_pkg::AcqStart, addr_byte);
    expect_entry(i3c_target_pkg::AcqStop, {exp[2][6:0], 1'b0});
    tx_q.delete();
  endtask

  // Stop comes right after an ACKed byte
  task automatic read_with_early_stop();
    logic [7:0] b0;
    logic [7:0] got;
    logic [7:0] addr_byte;
    logic       ack_sda;
    addr_byte = {OWN_ADDR, 1'b1};
    clear_counts();
    b0 = next_rand_byte();
    tx_q.push_back(b0);
    tx_q.push_back(next_rand_byte());
    send_start();
    write_byte(addr_byte, ack_sda);
    check_bit("SDA on address ACK bit", ack_sda, 1'b0);
    read_byte(1'b1, got);
    check_byte("byte read from sda_o", got, b0);
    send_stop();
    check_byte("event_unexp_stop_o pulses", unexp_cnt, 8'd1);
    check_byte("TX FIFO pops", pop_cnt, 8'd1);
    check_byte("event_cmd_complete_o pulses", done_cnt, 8'd1);
    expect_entry(i3c_target_pkg::AcqStart, addr_byte);
    expect_entry(i3c_target_pkg::AcqStop, {b0[6:0], 1'b0});
    tx_q.delete();
  endtask

  task automatic rx_backpressure();
    logic [7:0] addr_byte;
    logic       ack_sda;
    addr_byte = {OWN_ADDR, 1'b0};
    clear_counts();
    rx_wready = 1'b0;
    send_start();
    write_byte(addr_byte, ack_sda);
    check_bit("SDA on address ACK bit", ack_sda, 1'b1);
    send_stop();
    rx_wready = 1'b1;
    check_byte("event_target_nack_o pulses", nack_cnt, 8'd1);
    check_byte("event_cmd_complete_o pulses", done_cnt, 8'd1);
    expect_entry(i3c_target_pkg::AcqNackStop, {addr_byte[6:0], 1'b0});
    check_byte("RX FIFO extra writes", 8'(rx_q.size()), 8'd0);
  endtask

  // Enable drops while the target holds the address ACK
  task automatic enable_drop_mid_write();
    clear_counts();
    send_start();
    shift_out_byte({OWN_ADDR, 1'b0});
    wait_clks(QUARTER);
    check_bit("sda_o during address ACK", sda_out, 1'b0);
    enable = 1'b0;
    wait_clks(4);
    check_bit("target_idle_o after disable", idle, 1'b1);
    check_bit("sda_o after disable", sda_out, 1'b1);
    check_byte("RX FIFO writes", 8'(rx_q.size()), 8'd0);
    check_byte("event_cmd_complete_o pulses", done_cnt, 8'd0);
  endtask

  initial begin
    rst_n       = 1'b0;
    enable      = 1'b1;
    scl         = 1'b1;
    sda_host    = 1'b1;
    start_det   = 1'b0;
    stop_det    = 1'b0;
    tx_rvalid   = 1'b0;
    tx_rdata    = 8'h00;
    rx_wready   = 1'b1;
    t_r         = 13'd2;
    tsu_dat     = 13'd3;
    thd_dat     = 13'd2;
    target_addr = OWN_ADDR;
    lcg_state   = 32'd67717;
    errors      = 0;
    checks      = 0;
    clear_counts();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait_clks(2);
    idle_after_reset();
    private_write();
    wait_clks(HALF);
    addr_mismatch();
    wait_clks(HALF);
    private_read();
    wait_clks(HALF);
    read_with_early_stop();
    wait_clks(HALF);
    rx_backpressure();
    wait_clks(HALF);
    enable_drop_mid_write();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("ERROR: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: verilog/i3c_bus_if.sv
`timescale 1ns/1ns
`include "i3c_target_params.svh"

interface i3c_bus_if;

  // SCL edges and level as seen after one register stage
  logic                      scl_posedge;
  logic                      scl_negedge;
  logic                      scl_level;

  // Bit position within the nine-bit frame
  logic [`I3C_BIT_IDX_W-1:0] bit_idx;
  logic                      bit_ack;

  // Byte shifted in from the host, MSB first
  logic [`I3C_BYTE_W-1:0]    input_byte;

  // Host acknowledge of a byte sent by the target
  logic                      host_ack;

  modport sampler (
    output scl_posedge, scl_negedge, scl_level, bit_idx, bit_ack, input_byte, host_ack
  );

  modport fsm (
    input scl_posedge, scl_negedge, scl_level, bit_idx, bit_ack, input_byte, host_ack
  );

endinterface

// File: verilog/i3c_bus_sampler.sv
`timescale 1ns/1ns
`include "i3c_target_params.svh"

module i3c_bus_sampler (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     scl_i,
  input  logic     sda_i,
  input  logic     start_det_i,
  input  logic     input_byte_clr_i,
  i3c_bus_if.sampler bus_o
);

  logic                      scl_q;
  logic                      sda_q;
  logic                      scl_posedge_q;
  logic                      scl_negedge_q;
  logic [`I3C_BIT_IDX_W-1:0] bit_idx_q;
  logic                      bit_ack;
  logic [`I3C_BYTE_W-1:0]    input_byte_q;
  logic                      host_ack_q;

  // Bus idles high
  // Edge pulses line up with the new registered level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_q         <= 1'b1;
      sda_q         <= 1'b1;
      scl_posedge_q <= 1'b0;
      scl_negedge_q <= 1'b0;
    end else begin
      scl_q         <= scl_i;
      sda_q         <= sda_i;
      scl_posedge_q <= scl_i && !scl_q;
      scl_negedge_q <= !scl_i && scl_q;
    end
  end

  assign bit_ack = (bit_idx_q == `I3C_ACK_BIT_IDX);

  // Bit counter advances on falling SCL
  // Wraps to zero once the ACK bit is over
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q <= '0;
    end else if (start_det_i) begin
      bit_idx_q <= '0;
    end else if (scl_negedge_q) begin
      if (input_byte_clr_i || bit_ack) begin
        bit_idx_q <= '0;
      end else begin
        bit_idx_q <= bit_idx_q + 1'b1;
      end
    end
  end

  // Data bits shift in MSB first on rising SCL
  // The ACK bit is left out of the byte
  always_ff @(posedge clk_i) begin
    if (input_byte_clr_i) begin
      input_byte_q <= '0;
    end else if (scl_posedge_q && !bit_ack) begin
      input_byte_q <= {input_byte_q[`I3C_BYTE_W-2:0], sda_q};
    end
  end

  // Host pulls SDA low on the ninth bit to acknowledge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_ack_q <= 1'b0;
    end else if (scl_posedge_q && bit_ack) begin
      host_ack_q <= !sda_q;
    end
  end

  assign bus_o.scl_posedge = scl_posedge_q;
  assign bus_o.scl_negedge = scl_negedge_q;
  assign bus_o.scl_level   = scl_q;
  assign bus_o.bit_idx     = bit_idx_q;
  assign bus_o.bit_ack     = bit_ack;
  assign bus_o.input_byte  = input_byte_q;
  assign bus_o.host_ack    = host_ack_q;

endmodule

// File: verilog/i3c_hold_timer.sv
`timescale 1ns/1ns
`include "i3c_target_params.svh"

module i3c_hold_timer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       enable_i,
  input  logic                       load_i,
  input  i3c_target_pkg::tcount_sel_e sel_i,
  input  logic [`I3C_TIMING_W-1:0]   t_r_i,
  input  logic [`I3C_TIMING_W-1:0]   tsu_dat_i,
  input  logic [`I3C_TIMING_W-1:0]   thd_dat_i,
  output logic                       expired_o
);

  logic [`I3C_TCOUNT_W-1:0] tcount_q;
  logic [`I3C_TCOUNT_W-1:0] tcount_d;

  // Load the selected delay, else count down
  always_comb begin
    tcount_d = tcount_q;
    if (load_i) begin
      case (sel_i)
        i3c_target_pkg::tSetupData: begin
          tcount_d = `I3C_TCOUNT_W'(t_r_i) + `I3C_TCOUNT_W'(tsu_dat_i);
        end
        i3c_target_pkg::tHoldData: tcount_d = `I3C_TCOUNT_W'(thd_dat_i);
        default:                   tcount_d = `I3C_TCOUNT_W'(1);
      endcase
    end else if (enable_i) begin
      tcount_d = tcount_q - 1'b1;
    end
  end

  // Starts far from expiry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tcount_q <= '1;
    end else begin
      tcount_q <= tcount_d;
    end
  end

  assign expired_o = (tcount_q == `I3C_TCOUNT_W'(1));

endmodule

// File: verilog/i3c_target_fsm.sv
`timescale 1ns/1ns
`include "i3c_target_params.svh"

module i3c_target_fsm (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        target_enable_i,
  input  logic                        start_det_i,
  input  logic                        stop_det_i,
  input  logic [`I3C_ADDR_W-1:0]      target_addr_i,
  i3c_bus_if.fsm                      bus_i,
  input  logic                        timer_expired_i,
  output logic                        timer_load_o,
  output i3c_target_pkg::tcount_sel_e timer_sel_o,
  output logic                        input_byte_clr_o,
  input  logic                        tx_fifo_rvalid_i,
  input  logic [`I3C_BYTE_W-1:0]      tx_fifo_rdata_i,
  output logic                        tx_fifo_rready_o,
  input  logic                        rx_fifo_wready_i,
  output logic                        rx_fifo_wvalid_o,
  output i3c_target_pkg::rx_entry_t   rx_fifo_wdata_o,
  output logic                        sda_o,
  output logic                        target_transmitting_o,
  output logic                        target_idle_o,
  output logic                        event_target_nack_o,
  output logic                        event_cmd_complete_o,
  output logic                        event_unexp_stop_o,
  output logic                        event_read_cmd_received_o
);

  i3c_target_pkg::tgt_state_e state_q, state_d;

  logic       sda_q, sda_d;
  logic       rnw_q, rnw_d;
  // Addressed in the current transfer
  logic       xfer_for_us_q, xfer_for_us_d;
  // Rest of the transaction gets NACKed
  logic       nack_transaction_q, nack_transaction_d;
  logic       expect_stop;
  logic       addr_match;
  logic [2:0] tx_bit_sel;
  logic       tx_bit;

  // Upper seven bits hold the address, bit 0 is RnW
  assign addr_match = (bus_i.input_byte[`I3C_BYTE_W-1:1] == target_addr_i);

  // MSB goes out first
  // Empty TX FIFO leaves SDA released
  assign tx_bit_sel = 3'd7 - bus_i.bit_idx[2:0];
  assign tx_bit     = tx_fifo_rvalid_i ? tx_fifo_rdata_i[tx_bit_sel] : 1'b1;

  // Host NACKed or not addressed, a stop is due
  assign expect_stop = (state_q == i3c_target_pkg::WaitForStop);

  assign target_idle_o = (state_q == i3c_target_pkg::Idle);
  assign sda_o         = sda_q;

  assign event_target_nack_o = !nack_transaction_q && nack_transaction_d;
  // A read ended by stop without the host NACK
  assign event_unexp_stop_o  = target_enable_i && xfer_for_us_q && rnw_q &&
                               stop_det_i && !expect_stop;

  always_comb begin
    state_d                   = state_q;
    sda_d                     = 1'b1;
    target_transmitting_o     = 1'b0;
    timer_load_o              = 1'b0;
    timer_sel_o               = i3c_target_pkg::tNoDelay;
    input_byte_clr_o          = 1'b0;
    tx_fifo_rready_o          = 1'b0;
    rx_fifo_wvalid_o          = 1'b0;
    rx_fifo_wdata_o           = '{tag: i3c_target_pkg::AcqData, data: bus_i.input_byte};
    event_cmd_complete_o      = 1'b0;
    event_read_cmd_received_o = 1'b0;
    rnw_d                     = rnw_q;
    xfer_for_us_d             = xfer_for_us_q;
    nack_transaction_d        = nack_transaction_q;

    // ACK states pull SDA low for the whole ninth bit
    if (state_q inside {i3c_target_pkg::AddrAckSetup, i3c_target_pkg::AddrAckPulse,
                        i3c_target_pkg::AddrAckHold, i3c_target_pkg::AcquireAckSetup,
                        i3c_target_pkg::AcquireAckPulse, i3c_target_pkg::AcquireAckHold}) begin
      sda_d                 = 1'b0;
      target_transmitting_o = 1'b1;
    end

    // Data bit is kept through the high phase and the hold time
    if (state_q inside {i3c_target_pkg::TransmitPulse, i3c_target_pkg::TransmitHold}) begin
      sda_d                 = sda_q;
      target_transmitting_o = 1'b1;
    end

    case (state_q)
      i3c_target_pkg::Idle: begin
        xfer_for_us_d      = 1'b0;
        nack_transaction_d = 1'b0;
      end
      // Start seen, address begins after SCL falls
      i3c_target_pkg::AcquireStart: begin
        xfer_for_us_d = 1'b0;
        if (!bus_i.scl_level) begin
          input_byte_clr_o = 1'b1;
          state_d          = i3c_target_pkg::AddrRead;
        end
      end
      i3c_target_pkg::AddrRead: begin
        if (bus_i.bit_ack) begin
          if (addr_match) begin
            xfer_for_us_d = 1'b1;
            rnw_d         = bus_i.input_byte[0];
            timer_load_o  = 1'b1;
            timer_sel_o   = i3c_target_pkg::tHoldData;
            state_d       = i3c_target_pkg::AddrAckWait;
          end else begin
            state_d = i3c_target_pkg::WaitForStop;
          end
        end
      end
      // No room for the start entry, or host clocking too fast
      i3c_target_pkg::AddrAckWait: begin
        if (!rx_fifo_wready_i || bus_i.scl_level) begin
          nack_transaction_d = 1'b1;
        end
        if (bus_i.scl_level) begin
          state_d = i3c_target_pkg::WaitForStop;
        end else if (timer_expired_i) begin
          state_d = nack_transaction_d ? i3c_target_pkg::WaitForStop
                                       : i3c_target_pkg::AddrAckSetup;
        end
      end
      i3c_target_pkg::AddrAckSetup: begin
        if (bus_i.scl_level) state_d = i3c_target_pkg::AddrAckPulse;
      end
      i3c_target_pkg::AddrAckPulse: begin
        if (!bus_i.scl_level) begin
          timer_load_o = 1'b1;
          timer_sel_o  = i3c_target_pkg::tHoldData;
          state_d      = i3c_target_pkg::AddrAckHold;
        end
      end
      // Record the start once the ACK has been held
      i3c_target_pkg::AddrAckHold: begin
        if (timer_expired_i) begin
          rx_fifo_wvalid_o          = 1'b1;
          rx_fifo_wdata_o.tag       = i3c_target_pkg::AcqStart;
          event_read_cmd_received_o = rnw_q;
          state_d = rnw_q ? i3c_target_pkg::TransmitSetup : i3c_target_pkg::AcquireByte;
        end
      end
      // Hold time after the host ACK before the next MSB
      i3c_target_pkg::TransmitWait: begin
        if (timer_expired_i) state_d = i3c_target_pkg::TransmitSetup;
      end
      i3c_target_pkg::TransmitSetup: begin
        sda_d                 = tx_bit;
        target_transmitting_o = 1'b1;
        if (bus_i.scl_level) state_d = i3c_target_pkg::TransmitPulse;
      end
      i3c_target_pkg::TransmitPulse: begin
        if (!bus_i.scl_level) begin
          timer_load_o = 1'b1;
          timer_sel_o  = i3c_target_pkg::tHoldData;
          state_d      = i3c_target_pkg::TransmitHold;
        end
      end
      // Counter already moved on, so bit_ack means all eight bits are out
      i3c_target_pkg::TransmitHold: begin
        if (timer_expired_i) begin
          state_d = bus_i.bit_ack ? i3c_target_pkg::TransmitAck
                                  : i3c_target_pkg::TransmitSetup;
        end
      end
      i3c_target_pkg::TransmitAck: begin
        if (bus_i.scl_level) state_d = i3c_target_pkg::TransmitAckPulse;
      end
      // Pop once per ACKed byte, a NACK ends the read
      i3c_target_pkg::TransmitAckPulse: begin
        if (!bus_i.scl_level) begin
          if (bus_i.host_ack) begin
            tx_fifo_rready_o = tx_fifo_rvalid_i;
            timer_load_o     = 1'b1;
            timer_sel_o      = i3c_target_pkg::tHoldData;
            state_d          = i3c_target_pkg::TransmitWait;
          end else begin
            state_d = i3c_target_pkg::WaitForStop;
          end
        end
      end
      i3c_target_pkg::AcquireByte: begin
        if (bus_i.bit_ack) begin
          timer_load_o = 1'b1;
          timer_sel_o  = i3c_target_pkg::tHoldData;
          state_d      = i3c_target_pkg::AcquireAckWait;
        end
      end
      i3c_target_pkg::AcquireAckWait: begin
        if (!rx_fifo_wready_i || bus_i.scl_level) begin
          nack_transaction_d = 1'b1;
        end
        if (bus_i.scl_level) begin
          state_d = i3c_target_pkg::WaitForStop;
        end else if (timer_expired_i) begin
          state_d = nack_transaction_d ? i3c_target_pkg::WaitForStop
                                       : i3c_target_pkg::AcquireAckSetup;
        end
      end
      i3c_target_pkg::AcquireAckSetup: begin
        if (bus_i.scl_level) state_d = i3c_target_pkg::AcquireAckPulse;
      end
      i3c_target_pkg::AcquireAckPulse: begin
        if (!bus_i.scl_level) begin
          timer_load_o = 1'b1;
          timer_sel_o  = i3c_target_pkg::tHoldData;
          state_d      = i3c_target_pkg::AcquireAckHold;
        end
      end
      // Data byte goes to the RX FIFO as the ACK ends
      i3c_target_pkg::AcquireAckHold: begin
        if (timer_expired_i) begin
          rx_fifo_wvalid_o = 1'b1;
          state_d          = i3c_target_pkg::AcquireByte;
        end
      end
      // Only a stop or start gets out of here
      i3c_target_pkg::WaitForStop: begin
        state_d = i3c_target_pkg::WaitForStop;
      end
      default: state_d = i3c_target_pkg::Idle;
    endcase

    // Enable, stop and start win over the bit sequencing
    if (!target_enable_i) begin
      state_d = i3c_target_pkg::Idle;
    end else if (stop_det_i) begin
      state_d              = i3c_target_pkg::Idle;
      event_cmd_complete_o = xfer_for_us_q;
      // Stop entry goes in even without wready
      if (xfer_for_us_q) begin
        rx_fifo_wvalid_o    = 1'b1;
        rx_fifo_wdata_o.tag = nack_transaction_q ? i3c_target_pkg::AcqNackStop
                                                 : i3c_target_pkg::AcqStop;
      end
    end else if (start_det_i) begin
      state_d = i3c_target_pkg::AcquireStart;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= i3c_target_pkg::Idle;
      sda_q              <= 1'b1;
      rnw_q              <= 1'b0;
      xfer_for_us_q      <= 1'b0;
      nack_transaction_q <= 1'b0;
    end else begin
      state_q            <= state_d;
      sda_q              <= sda_d;
      rnw_q              <= rnw_d;
      xfer_for_us_q      <= xfer_for_us_d;
      nack_transaction_q <= nack_transaction_d;
    end
  end

endmodule

// File: verilog/i3c_target_params.svh
`ifndef I3C_TARGET_PARAMS_SVH
`define I3C_TARGET_PARAMS_SVH

// Width of each timing input in clock cycles
`define I3C_TIMING_W 13

// Delay counter width, wide enough for rise plus setup
`define I3C_TCOUNT_W 16

// Serial byte and bit index
`define I3C_BYTE_W 8
`define I3C_BIT_IDX_W 4

// Bit index of the ninth (ACK) bit
`define I3C_ACK_BIT_IDX 8

// Static address width
`define I3C_ADDR_W 7

`endif

// File: verilog/i3c_target_pkg.sv
`include "i3c_target_params.svh"

package i3c_target_pkg;

  // Target FSM states
  typedef enum logic [4:0] {
    Idle,
    AcquireStart,
    AddrRead,
    AddrAckWait,
    AddrAckSetup,
    AddrAckPulse,
    AddrAckHold,
    TransmitWait,
    TransmitSetup,
    TransmitPulse,
    TransmitHold,
    TransmitAck,
    TransmitAckPulse,
    WaitForStop,
    AcquireByte,
    AcquireAckWait,
    AcquireAckSetup,
    AcquireAckPulse,
    AcquireAckHold
  } tgt_state_e;

  // Delay select for the hold timer
  typedef enum logic [1:0] {
    tSetupData,
    tHoldData,
    tNoDelay
  } tcount_sel_e;

  // Tag of an RX FIFO entry
  typedef enum logic [1:0] {
    AcqData,
    AcqStart,
    AcqStop,
    AcqNackStop
  } acq_tag_e;

  // RX FIFO word, tag on top of the byte
  typedef struct packed {
    acq_tag_e                tag;
    logic [`I3C_BYTE_W-1:0]  data;
  } rx_entry_t;

endpackage

// File: verilog/i3c_target_top.sv
`timescale 1ns/1ns
`include "i3c_target_params.svh"

module i3c_target_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      target_enable_i,
  // Bus pins and monitor pulses
  input  logic                      scl_i,
  input  logic                      sda_i,
  input  logic                      start_det_i,
  input  logic                      stop_det_i,
  output logic                      sda_o,
  output logic                      target_transmitting_o,
  // TX FIFO read side
  input  logic                      tx_fifo_rvalid_i,
  input  logic [`I3C_BYTE_W-1:0]    tx_fifo_rdata_i,
  output logic                      tx_fifo_rready_o,
  // RX FIFO write side
  output logic                      rx_fifo_wvalid_o,
  output i3c_target_pkg::rx_entry_t rx_fifo_wdata_o,
  input  logic                      rx_fifo_wready_i,
  // Timing in clock cycles
  input  logic [`I3C_TIMING_W-1:0]  t_r_i,
  input  logic [`I3C_TIMING_W-1:0]  tsu_dat_i,
  input  logic [`I3C_TIMING_W-1:0]  thd_dat_i,
  input  logic [`I3C_ADDR_W-1:0]    target_addr_i,
  // Status and events
  output logic                      target_idle_o,
  output logic                      event_target_nack_o,
  output logic                      event_cmd_complete_o,
  output logic                      event_unexp_stop_o,
  output logic                      event_read_cmd_received_o
);

  logic                        input_byte_clr;
  logic                        timer_load;
  logic                        timer_expired;
  i3c_target_pkg::tcount_sel_e timer_sel;

  i3c_bus_if bus_if ();

  i3c_bus_sampler u_sampler (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .scl_i            (scl_i),
    .sda_i            (sda_i),
    .start_det_i      (start_det_i),
    .input_byte_clr_i (input_byte_clr),
    .bus_o            (bus_if)
  );

  // Counts only while the target is enabled
  i3c_hold_timer u_timer (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .enable_i  (target_enable_i),
    .load_i    (timer_load),
    .sel_i     (timer_sel),
    .t_r_i     (t_r_i),
    .tsu_dat_i (tsu_dat_i),
    .thd_dat_i (thd_dat_i),
    .expired_o (timer_expired)
  );

  i3c_target_fsm u_fsm (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .target_enable_i           (target_enable_i),
    .start_det_i               (start_det_i),
    .stop_det_i                (stop_det_i),
    .target_addr_i             (target_addr_i),
    .bus_i                     (bus_if),
    .timer_expired_i           (timer_expired),
    .timer_load_o              (timer_load),
    .timer_sel_o               (timer_sel),
    .input_byte_clr_o          (input_byte_clr),
    .tx_fifo_rvalid_i          (tx_fifo_rvalid_i),
    .tx_fifo_rdata_i           (tx_fifo_rdata_i),
    .tx_fifo_rready_o          (tx_fifo_rready_o),
    .rx_fifo_wready_i          (rx_fifo_wready_i),
    .rx_fifo_wvalid_o          (rx_fifo_wvalid_o),
    .rx_fifo_wdata_o           (rx_fifo_wdata_o),
    .sda_o                     (sda_o),
    .target_transmitting_o     (target_transmitting_o),
    .target_idle_o             (target_idle_o),
    .event_target_nack_o       (event_target_nack_o),
    .event_cmd_complete_o      (event_cmd_complete_o),
    .event_unexp_stop_o        (event_unexp_stop_o),
    .event_read_cmd_received_o (event_read_cmd_received_o)
  );

endmodule
